// ==== exe_alu.sv ====
`timescale 1ns/100ps

module exe_alu (
    input  exe_isa_pkg::alu_op_e   alu_op,
    input  exe_isa_pkg::src1_sel_e src1_sel,
    input  exe_isa_pkg::src2_sel_e src2_sel,
    input  logic                   of_check,
    input  logic [15:0]            imm,
    input  exe_isa_pkg::word_t     rs_value,
    input  exe_isa_pkg::word_t     rt_value,
    input  exe_isa_pkg::word_t     pc,
    output exe_isa_pkg::word_t     result,
    output logic                   overflow
);

    import exe_isa_pkg::*;

    word_t      src1;
    word_t      src2;
    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;

    // operand select
    always_comb begin
        case (src1_sel)
            src1_pc: src1 = pc;
            src1_sa: src1 = {27'b0, imm[10:6]};
            default: src1 = rs_value;
        endcase
    end

    always_comb begin
        case (src2_sel)
            src2_imm_sext: src2 = {{16{imm[15]}}, imm};
            src2_imm_zext: src2 = {16'b0, imm};
            src2_const8:   src2 = 32'd8;
            default:       src2 = rt_value;
        endcase
    end

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_nor:  result = ~(src1 | src2);
            alu_sll:  result = src2 << shamt;
            alu_srl:  result = src2 >> shamt;
            alu_sra:  result = $signed(src2) >>> shamt;
            alu_lui:  result = {src2[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

    // only add and sub with of_check can trap
    always_comb begin
        overflow = 1'b0;
        if (of_check) begin
            if (alu_op == alu_add) begin
                overflow = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            end else if (alu_op == alu_sub) begin
                overflow = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            end
        end
    end

endmodule

// ==== exe_bus_pkg.sv ====
package exe_bus_pkg;

    import exe_isa_pkg::*;

    // decode to execute
    typedef struct packed {
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      of_check;
        mem_op_e   mem_op;
        hilo_op_e  hilo_op;
        logic      gr_we;
        reg_addr_t dest;
        logic [15:0] imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        exc_code_e ex_code;
        logic      slot;
    } ds_to_es_t;

    // execute to memory
    typedef struct packed {
        word_t     pc;
        word_t     result;
        logic      gr_we;
        reg_addr_t dest;
        mem_op_e   mem_op;
        logic [1:0] byte_off;
        exc_code_e ex_code;
        word_t     bad_vaddr;
        logic      slot;
    } es_to_ms_t;

    // size is 0 byte, 1 half, 2 word
    typedef struct packed {
        logic       wr;
        logic [1:0] size;
        logic [3:0] wstrb;
        word_t      addr;
        word_t      wdata;
    } sram_req_t;

endpackage

// ==== exe_hilo.sv ====
`timescale 1ns/100ps

module exe_hilo (
    input  logic                  clk,
    input  logic                  reset,
    input  exe_isa_pkg::hilo_op_e hilo_op,
    input  logic                  commit,
    input  exe_isa_pkg::word_t    rs_value,
    input  exe_isa_pkg::word_t    rt_value,
    output exe_isa_pkg::word_t    read_value
);

    import exe_isa_pkg::*;

    word_t       hi;
    word_t       lo;
    logic        is_signed;
    logic [32:0] mul_a;
    logic [32:0] mul_b;
    logic [65:0] product;

    // one 33x33 signed multiplier covers mult and multu
    assign is_signed = (hilo_op == hilo_mult);
    assign mul_a     = {is_signed & rs_value[31], rs_value};
    assign mul_b     = {is_signed & rt_value[31], rt_value};
    assign product   = $signed(mul_a) * $signed(mul_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (hilo_op)
                hilo_mult, hilo_multu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                hilo_mthi: hi <= rs_value;
                hilo_mtlo: lo <= rs_value;
                default: ;
            endcase
        end
    end

    assign read_value = (hilo_op == hilo_mfhi) ? hi : lo;

endmodule

// ==== exe_isa_pkg.sv ====
package exe_isa_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lw,
        mem_lh,
        mem_lhu,
        mem_lb,
        mem_lbu,
        mem_sw,
        mem_sh,
        mem_sb
    } mem_op_e;

    // cause register values, no_ex is an unused code
    typedef enum logic [4:0] {
        exc_adel  = 5'h04,
        exc_ades  = 5'h05,
        exc_ov    = 5'h0c,
        exc_no_ex = 5'h1f
    } exc_code_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_pc,
        src1_sa
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_imm_sext,
        src2_imm_zext,
        src2_const8
    } src2_sel_e;

    typedef enum logic [2:0] {
        hilo_none,
        hilo_mult,
        hilo_multu,
        hilo_mthi,
        hilo_mtlo,
        hilo_mfhi,
        hilo_mflo
    } hilo_op_e;

endpackage

// ==== exe_mem_access.sv ====
`timescale 1ns/100ps

module exe_mem_access (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  logic                   load,
    input  exe_isa_pkg::mem_op_e   mem_op,
    input  exe_isa_pkg::word_t     addr,
    input  exe_isa_pkg::word_t     rt_value,
    input  logic                   prior_ex,
    output logic                   data_sram_en,
    output exe_bus_pkg::sram_req_t data_sram_req,
    input  logic                   data_sram_addr_ok,
    output logic                   mem_ready,
    output exe_isa_pkg::exc_code_e addr_error,
    output logic [1:0]             byte_off
);

    import exe_isa_pkg::*;

    logic is_mem;
    logic is_store;
    logic adel;
    logic ades;
    logic need_req;
    logic req_sent;

    assign is_mem   = (mem_op != mem_none);
    assign is_store = (mem_op == mem_sw) || (mem_op == mem_sh) || (mem_op == mem_sb);
    assign byte_off = addr[1:0];

    // alignment checks
    assign adel = ((mem_op == mem_lw) && (addr[1:0] != 2'b00))
               || (((mem_op == mem_lh) || (mem_op == mem_lhu)) && addr[0]);
    assign ades = ((mem_op == mem_sw) && (addr[1:0] != 2'b00))
               || ((mem_op == mem_sh) && addr[0]);

    always_comb begin
        if (adel) begin
            addr_error = exc_adel;
        end else if (ades) begin
            addr_error = exc_ades;
        end else begin
            addr_error = exc_no_ex;
        end
    end

    assign need_req = valid && is_mem && !prior_ex && !adel && !ades;

    // a new instruction rearms the request
    always_ff @(posedge clk) begin
        if (reset || load) begin
            req_sent <= 1'b0;
        end else if (data_sram_en && data_sram_addr_ok) begin
            req_sent <= 1'b1;
        end
    end

    assign data_sram_en = need_req && !req_sent;
    assign mem_ready    = !need_req || req_sent || data_sram_addr_ok;

    always_comb begin
        data_sram_req.wr   = is_store;
        data_sram_req.addr = addr;
        case (mem_op)
            mem_sb, mem_lb, mem_lbu: begin
                data_sram_req.size  = 2'd0;
                data_sram_req.wdata = {4{rt_value[7:0]}};
                data_sram_req.wstrb = is_store ? (4'b0001 << addr[1:0]) : 4'b0000;
            end
            mem_sh, mem_lh, mem_lhu: begin
                data_sram_req.size  = 2'd1;
                data_sram_req.wdata = {2{rt_value[15:0]}};
                data_sram_req.wstrb = !is_store ? 4'b0000 :
                                      addr[1]   ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_sram_req.size  = 2'd2;
                data_sram_req.wdata = rt_value;
                data_sram_req.wstrb = is_store ? 4'b1111 : 4'b0000;
            end
        endcase
    end

endmodule

// ==== exe_stage.f ====
exe_isa_pkg.sv
exe_bus_pkg.sv
exe_alu.sv
exe_hilo.sv
exe_mem_access.sv
exe_stage.sv
tb_exe_stage.sv

// ==== exe_stage.sv ====
`timescale 1ns/100ps

module exe_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ds_to_es_valid,
    input  exe_bus_pkg::ds_to_es_t ds_to_es_bus,
    output logic                   es_allowin,
    output logic                   es_to_ms_valid,
    output exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    input  logic                   ms_allowin,
    output logic                   data_sram_en,
    output exe_bus_pkg::sram_req_t data_sram_req,
    input  logic                   data_sram_addr_ok
);

    import exe_isa_pkg::*;
    import exe_bus_pkg::*;

    ds_to_es_t  ds_r;
    logic       es_valid;
    logic       es_ready_go;
    logic       load;
    logic       commit;
    word_t      alu_result;
    logic       overflow;
    word_t      hilo_value;
    logic       mem_ready;
    exc_code_e  addr_error;
    logic [1:0] byte_off;
    logic       prior_ex;
    logic       addr_err_taken;
    exc_code_e  ex_code;

    assign load           = ds_to_es_valid && es_allowin;
    assign es_ready_go    = mem_ready;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    // hi/lo only change for an instruction leaving without exception
    assign commit         = es_to_ms_valid && ms_allowin && (ex_code == exc_no_ex);

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ds_r <= ds_to_es_bus;
        end
    end

    exe_alu u_alu (
        .alu_op   (ds_r.alu_op),
        .src1_sel (ds_r.src1_sel),
        .src2_sel (ds_r.src2_sel),
        .of_check (ds_r.of_check),
        .imm      (ds_r.imm),
        .rs_value (ds_r.rs_value),
        .rt_value (ds_r.rt_value),
        .pc       (ds_r.pc),
        .result   (alu_result),
        .overflow (overflow)
    );

    exe_hilo u_hilo (
        .clk        (clk),
        .reset      (reset),
        .hilo_op    (ds_r.hilo_op),
        .commit     (commit),
        .rs_value   (ds_r.rs_value),
        .rt_value   (ds_r.rt_value),
        .read_value (hilo_value)
    );

    assign prior_ex = (ds_r.ex_code != exc_no_ex) || overflow;

    exe_mem_access u_mem_access (
        .clk               (clk),
        .reset             (reset),
        .valid             (es_valid),
        .load              (load),
        .mem_op            (ds_r.mem_op),
        .addr              (alu_result),
        .rt_value          (ds_r.rt_value),
        .prior_ex          (prior_ex),
        .data_sram_en      (data_sram_en),
        .data_sram_req     (data_sram_req),
        .data_sram_addr_ok (data_sram_addr_ok),
        .mem_ready         (mem_ready),
        .addr_error        (addr_error),
        .byte_off          (byte_off)
    );

    // upstream, then overflow, then address error
    assign addr_err_taken = !prior_ex && (addr_error != exc_no_ex);

    always_comb begin
        if (ds_r.ex_code != exc_no_ex) begin
            ex_code = ds_r.ex_code;
        end else if (overflow) begin
            ex_code = exc_ov;
        end else begin
            ex_code = addr_error;
        end
    end

    always_comb begin
        es_to_ms_bus.pc        = ds_r.pc;
        es_to_ms_bus.result    = ((ds_r.hilo_op == hilo_mfhi) || (ds_r.hilo_op == hilo_mflo))
                               ? hilo_value : alu_result;
        es_to_ms_bus.gr_we     = ds_r.gr_we;
        es_to_ms_bus.dest      = ds_r.dest;
        // no request went out, so memory must not wait for data
        es_to_ms_bus.mem_op    = (ex_code == exc_no_ex) ? ds_r.mem_op : mem_none;
        es_to_ms_bus.byte_off  = byte_off;
        es_to_ms_bus.ex_code   = ex_code;
        es_to_ms_bus.bad_vaddr = addr_err_taken ? alu_result : '0;
        es_to_ms_bus.slot      = ds_r.slot;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f exe_stage.f --top-module tb_exe_stage \
    && ./obj_dir/Vtb_exe_stage > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb_exe_stage.sv ====
`timescale 1ns/100ps

module tb_exe_stage;

    import exe_isa_pkg::*;
    import exe_bus_pkg::*;

    localparam logic [31:0] seed = 32'h44f63ef7;
    localparam int num_instr = 400;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      es_allowin;
    logic      es_to_ms_valid;
    es_to_ms_t es_to_ms_bus;
    logic      ms_allowin;
    logic      data_sram_en;
    sram_req_t data_sram_req;
    logic      data_sram_addr_ok;

    logic [31:0] instr_rng;
    logic [31:0] flow_rng;
    logic [31:0] flow;
    word_t       model_hi;
    word_t       model_lo;
    ds_to_es_t   in_q[$];
    es_to_ms_t   exp_q[$];
    logic        need_q[$];
    logic        accepted;
    int          req_count;
    logic        held_valid;
    es_to_ms_t   held_bus;
    int          errors;
    int          checks;
    int          sent;
    logic        timed_out;

    exe_stage dut0 (
        .clk               (clk),
        .reset             (reset),
        .ds_to_es_valid    (ds_to_es_valid),
        .ds_to_es_bus      (ds_to_es_bus),
        .es_allowin        (es_allowin),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .ms_allowin        (ms_allowin),
        .data_sram_en      (data_sram_en),
        .data_sram_req     (data_sram_req),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // word built from the upper halves of two lcg steps
    function automatic logic [31:0] rand_word(inout logic [31:0] state);
        logic [15:0] hi_part;
        state = lcg_next(state);
        hi_part = state[31:16];
        state = lcg_next(state);
        return {hi_part, state[31:16]};
    endfunction

    function automatic ds_to_es_t make_instr();
        ds_to_es_t   d;
        logic [31:0] kind;
        logic [31:0] r;
        logic [31:0] r2;
        d = '0;
        kind = rand_word(instr_rng) % 8;
        r = rand_word(instr_rng);
        r2 = rand_word(instr_rng);
        d.alu_op   = alu_op_e'(4'(r % 12));
        d.src1_sel = src1_sel_e'(2'(r2 % 3));
        d.src2_sel = src2_sel_e'(2'(r[31:16] % 4));
        d.of_check = r2[20];
        d.mem_op   = mem_none;
        d.hilo_op  = hilo_none;
        d.gr_we    = r[21];
        d.dest     = r2[28:24];
        d.imm      = 16'(rand_word(instr_rng));
        d.rs_value = rand_word(instr_rng);
        d.rt_value = rand_word(instr_rng);
        d.pc       = rand_word(instr_rng) << 2;
        d.slot     = r[22];
        case (kind)
            3: begin
                // operands chosen so the signed result always wraps
                d.alu_op   = r[0] ? alu_add : alu_sub;
                d.src1_sel = src1_rs;
                d.src2_sel = src2_rt;
                d.of_check = r[1];
                d.rs_value = {r[0] ? 4'h7 : 4'h8, d.rs_value[27:0]};
                d.rt_value = {4'h7, d.rt_value[27:0]};
            end
            4, 5: begin
                d.alu_op   = alu_add;
                d.src1_sel = src1_rs;
                d.src2_sel = src2_imm_sext;
                d.of_check = 1'b0;
                d.mem_op   = mem_op_e'(4'(1 + r % 8));
                d.rs_value = {d.rs_value[31:2], 2'b00};
                d.imm      = {13'b0, r2[2:0]};
            end
            6, 7: begin
                d.of_check = 1'b0;
                d.hilo_op  = hilo_op_e'(3'(1 + r % 6));
            end
            default: ;
        endcase
        d.ex_code = (rand_word(instr_rng) % 8 == 0) ? exc_adel : exc_no_ex;
        return d;
    endfunction

    // reference model called in acceptance order so hi/lo advance in step
    function automatic es_to_ms_t model_step(input ds_to_es_t d, output logic need);
        es_to_ms_t   e;
        word_t       a;
        word_t       b;
        word_t       r;
        logic [32:0] wide;
        logic [63:0] p;
        logic        ovf;
        exc_code_e   aerr;
        exc_code_e   ex;
        a = (d.src1_sel == src1_pc) ? d.pc :
            (d.src1_sel == src1_sa) ? {27'b0, d.imm[10:6]} : d.rs_value;
        case (d.src2_sel)
            src2_imm_sext: b = {{16{d.imm[15]}}, d.imm};
            src2_imm_zext: b = {16'h0000, d.imm};
            src2_const8:   b = 32'd8;
            default:       b = d.rt_value;
        endcase
        case (d.alu_op)
            alu_add:  r = a + b;
            alu_sub:  r = a - b;
            alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_nor:  r = ~(a | b);
            alu_sll:  r = b << a[4:0];
            alu_srl:  r = b >> a[4:0];
            alu_sra:  r = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
            alu_lui:  r = {b[15:0], 16'h0000};
            default:  r = 32'h0;
        endcase
        if (d.alu_op == alu_sub) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            wide = {a[31], a} + {b[31], b};
        end
        ovf = d.of_check && (d.alu_op inside {alu_add, alu_sub}) && (wide[32] != wide[31]);
        aerr = exc_no_ex;
        if ((d.mem_op == mem_lw && r[1:0] != 2'b00) ||
            (d.mem_op inside {mem_lh, mem_lhu} && r[0])) begin
            aerr = exc_adel;
        end
        if ((d.mem_op == mem_sw && r[1:0] != 2'b00) || (d.mem_op == mem_sh && r[0])) begin
            aerr = exc_ades;
        end
        ex = (d.ex_code != exc_no_ex) ? d.ex_code : (ovf ? exc_ov : aerr);
        e.pc        = d.pc;
        e.result    = (d.hilo_op == hilo_mfhi) ? model_hi :
                      (d.hilo_op == hilo_mflo) ? model_lo : r;
        e.gr_we     = d.gr_we;
        e.dest      = d.dest;
        e.mem_op    = (ex == exc_no_ex) ? d.mem_op : mem_none;
        e.byte_off  = r[1:0];
        e.ex_code   = ex;
        e.bad_vaddr = (d.ex_code == exc_no_ex && !ovf && aerr != exc_no_ex) ? r : 32'h0;
        e.slot      = d.slot;
        need = (ex == exc_no_ex) && (d.mem_op != mem_none);
        if (ex == exc_no_ex) begin
            case (d.hilo_op)
                hilo_mult: begin
                    p = $signed({{32{d.rs_value[31]}}, d.rs_value})
                      * $signed({{32{d.rt_value[31]}}, d.rt_value});
                    model_hi = p[63:32];
                    model_lo = p[31:0];
                end
                hilo_multu: begin
                    p = {32'h0, d.rs_value} * {32'h0, d.rt_value};
                    model_hi = p[63:32];
                    model_lo = p[31:0];
                end
                hilo_mthi: model_hi = d.rs_value;
                hilo_mtlo: model_lo = d.rs_value;
                default: ;
            endcase
        end
        return e;
    endfunction

    function automatic sram_req_t expect_request(input ds_to_es_t d, input word_t addr);
        sram_req_t q;
        q.addr  = addr;
        q.wr    = d.mem_op inside {mem_sb, mem_sh, mem_sw};
        q.wstrb = 4'b0000;
        case (d.mem_op)
            mem_lb, mem_lbu, mem_sb: begin
                q.size  = 2'd0;
                q.wdata = {4{d.rt_value[7:0]}};
                if (q.wr) begin
                    q.wstrb[addr[1:0]] = 1'b1;
                end
            end
            mem_lh, mem_lhu, mem_sh: begin
                q.size  = 2'd1;
                q.wdata = {2{d.rt_value[15:0]}};
                if (q.wr) begin
                    q.wstrb = addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            default: begin
                q.size  = 2'd2;
                q.wdata = d.rt_value;
                if (q.wr) begin
                    q.wstrb = 4'b1111;
                end
            end
        endcase
        return q;
    endfunction

    task automatic check_request();
        sram_req_t want;
        assert (exp_q.size() > 0 && need_q[0] && !accepted) else begin
            errors++;
            $display("Fail %0t: data_sram_en high with no request pending", $time);
        end
        if (exp_q.size() > 0) begin
            want = expect_request(in_q[0], exp_q[0].result);
            assert (data_sram_req == want) else begin
                errors++;
                $display("Fail %0t: sram request %h expected %h", $time, data_sram_req, want);
            end
            if (data_sram_addr_ok) begin
                accepted = 1'b1;
                req_count++;
            end
        end
    endtask

    task automatic check_output();
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("Fail %0t: output valid with no instruction outstanding", $time);
        end
        if (exp_q.size() > 0) begin
            assert (es_to_ms_bus == exp_q[0]) else begin
                errors++;
                $display("Fail %0t: es_to_ms_bus %h expected %h", $time, es_to_ms_bus, exp_q[0]);
            end
            assert (req_count == (need_q[0] ? 1 : 0)) else begin
                errors++;
                $display("Fail %0t: %0d accepted requests for one instruction", $time, req_count);
            end
            void'(in_q.pop_front());
            void'(exp_q.pop_front());
            void'(need_q.pop_front());
            accepted = 1'b0;
            req_count = 0;
            checks++;
        end
    endtask

    // memory side stalls and address acceptance
    always @(posedge clk) begin
        #2;
        flow = rand_word(flow_rng);
        ms_allowin = (flow[1:0] != 2'b00);
        data_sram_addr_ok = flow[2];
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (held_valid) begin
                assert (es_to_ms_valid && es_to_ms_bus == held_bus) else begin
                    errors++;
                    $display("Fail %0t: es_to_ms_bus changed while stalled", $time);
                end
            end
            held_valid = es_to_ms_valid && !ms_allowin;
            held_bus = es_to_ms_bus;
            if (data_sram_en) begin
                check_request();
            end
            if (es_to_ms_valid && ms_allowin) begin
                check_output();
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && !ms_allowin) |-> !es_allowin)
        else begin
            errors++;
            $display("Fail %0t: es_allowin high while the output is stalled", $time);
        end

    // an accepting addr_ok releases the instruction in the same cycle
    assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> (es_to_ms_valid == data_sram_addr_ok))
        else begin
            errors++;
            $display("Fail %0t: es_to_ms_valid does not follow addr_ok", $time);
        end

    task automatic send_instr(input ds_to_es_t instr);
        int        waited;
        logic      need;
        es_to_ms_t e;
        ds_to_es_valid = 1'b1;
        ds_to_es_bus = instr;
        waited = 0;
        @(negedge clk);
        while (!es_allowin && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!es_allowin) begin
            timed_out = 1'b1;
            $display("timeout: the stage accepted no instruction for 100 cycles");
        end else begin
            e = model_step(instr, need);
            in_q.push_back(instr);
            exp_q.push_back(e);
            need_q.push_back(need);
            sent++;
        end
        @(posedge clk);
        #2;
        ds_to_es_valid = 1'b0;
    endtask

    initial begin
        int i;
        int waited;
        clk = 1'b0;
        reset = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus = '0;
        ms_allowin = 1'b1;
        data_sram_addr_ok = 1'b0;
        instr_rng = seed;
        flow_rng = ~seed;
        model_hi = 32'h0;
        model_lo = 32'h0;
        accepted = 1'b0;
        req_count = 0;
        held_valid = 1'b0;
        errors = 0;
        checks = 0;
        sent = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!es_to_ms_valid && !data_sram_en && es_allowin) else begin
            errors++;
            $display("Fail %0t: stage not idle after reset", $time);
        end
        @(posedge clk);
        #2;
        for (i = 0; i < num_instr && !timed_out; i++) begin
            send_instr(make_instr());
            if (rand_word(instr_rng) % 4 == 0) begin
                @(posedge clk);
                #2;
            end
        end
        waited = 0;
        while (exp_q.size() > 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d instructions never left the stage", exp_q.size());
        end
        $display("instructions %0d, checks %0d, errors %0d", sent, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
